// ==== src.f ====
+incdir+logic
logic/vec_pkg.sv
logic/vec_cmd_queue.sv
logic/vec_uop_counter.sv
logic/vec_uop_seq.sv
logic/vec_alu.sv
logic/vec_vrf.sv
logic/vec_backend.sv
bench/vec_backend_tb.sv

// ==== Bender.yml ====
package:
  name: vec_backend

sources:
  - include_dirs:
      - logic
    files:
      - logic/vec_pkg.sv
      - logic/vec_cmd_queue.sv
      - logic/vec_uop_counter.sv
      - logic/vec_uop_seq.sv
      - logic/vec_alu.sv
      - logic/vec_vrf.sv
      - logic/vec_backend.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/vec_backend_tb.sv

// ==== bench/vec_backend_tb.sv ====
`timescale 1ns/100ps
`include "vec_settings.svh"

module vec_backend_tb;

  logic                 clk;
  logic                 rst_n;
  logic                 inst_valid;
  vec_pkg::vec_inst_u   inst;
  logic                 inst_ready;
  logic                 rt_valid;
  logic [2:0]           rt_vd;
  logic [`VEC_VLEN-1:0] rt_data;
  logic                 rt_vxsat;
  logic                 rt_last;
  logic                 vxsat;
  logic [2:0]           dbg_idx;
  logic [`VEC_VLEN-1:0] dbg_data;

  // Reference model state and expected retires in order
  logic [`VEC_VLEN-1:0] mregs [`VEC_NUM_VREG];
  logic                 m_sew16;
  int                   m_grp;
  logic                 m_vxsat;
  logic [2:0]           exp_vd [$];
  logic [`VEC_VLEN-1:0] exp_data [$];
  logic                 exp_sat [$];
  logic                 exp_last [$];

  logic [31:0] rng_state;
  logic        ready_low_seen;
  string       cur_test;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;

  vec_backend DUT (.*);

  always #2 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $finish;
  endtask

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic check_data(input string what, input logic [`VEC_VLEN-1:0] exp, act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %h, got %h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp, act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %b, got %b", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_vd(input string what, input logic [2:0] exp, act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %0d, got %0d", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  function automatic vec_pkg::vec_inst_u make_arith(input vec_pkg::alu_op_e op,
                                                    input logic [2:0] vd, vs1, vs2,
                                                    input logic [15:0] imm);
    vec_pkg::vec_inst_u u;
    u = '0;
    u.arith.op  = op;
    u.arith.vd  = vd;
    u.arith.vs1 = vs1;
    u.arith.vs2 = vs2;
    u.arith.imm = imm;
    return u;
  endfunction

  function automatic vec_pkg::vec_inst_u make_cfg(input logic sew16, input logic [1:0] lmul_log,
                                                  input logic clr);
    vec_pkg::vec_inst_u u;
    u = '0;
    u.cfg.kind      = 1'b1;
    u.cfg.sew16     = sew16;
    u.cfg.lmul_log  = lmul_log;
    u.cfg.clr_vxsat = clr;
    return u;
  endfunction

  // Signed lanes, each result clamped to the element range
  function automatic logic [`VEC_VLEN-1:0] lane_result(input vec_pkg::alu_op_e op,
      input logic [`VEC_VLEN-1:0] a, b, input logic [15:0] imm, input logic sew16,
      output logic sat);
    int                   ea;
    int                   eb;
    int                   r;
    int                   hi;
    int                   lo;
    logic [`VEC_VLEN-1:0] res;
    hi  = sew16 ? 32767 : 127;
    lo  = sew16 ? -32768 : -128;
    res = '0;
    sat = 1'b0;
    for (int l = 0; l < (sew16 ? `VEC_VLEN / 16 : `VEC_VLEN / 8); l++) begin
      if (sew16) begin
        ea = $signed(a[l*16 +: 16]);
        eb = $signed(b[l*16 +: 16]);
      end else begin
        ea = $signed(a[l*8 +: 8]);
        eb = $signed(b[l*8 +: 8]);
      end
      case (op)
        vec_pkg::op_sadd:  r = ea + eb;
        vec_pkg::op_ssub:  r = ea - eb;
        vec_pkg::op_splat: r = sew16 ? $signed(imm) : $signed(imm[7:0]);
        default:           r = 0;
      endcase
      if (r > hi) begin
        r   = hi;
        sat = 1'b1;
      end else if (r < lo) begin
        r   = lo;
        sat = 1'b1;
      end
      if (sew16) res[l*16 +: 16] = r[15:0];
      else res[l*8 +: 8] = r[7:0];
    end
    return res;
  endfunction

  task automatic model_inst(input vec_pkg::vec_inst_u x);
    logic [`VEC_VLEN-1:0] res;
    logic [`VEC_VLEN-1:0] pend_data;
    logic [2:0]           pend_idx;
    logic                 pend_en;
    logic                 sat;
    if (x.cfg.kind) begin
      m_sew16 = x.cfg.sew16;
      m_grp   = (x.cfg.lmul_log == 2'd0) ? 1 : (x.cfg.lmul_log == 2'd1) ? 2 : `VEC_MAX_LMUL;
      if (x.cfg.clr_vxsat) m_vxsat = 1'b0;
    end else begin
      pend_en = 1'b0;
      pend_idx = '0;
      pend_data = '0;
      for (int k = 0; k < m_grp; k++) begin
        res = lane_result(x.arith.op, mregs[x.arith.vs1 + 3'(k)], mregs[x.arith.vs2 + 3'(k)],
                          x.arith.imm, m_sew16, sat);
        // Previous uop lands only after this one has read its operands
        if (pend_en) mregs[pend_idx] = pend_data;
        pend_en   = 1'b1;
        pend_idx  = x.arith.vd + 3'(k);
        pend_data = res;
        exp_vd.push_back(pend_idx);
        exp_data.push_back(res);
        exp_sat.push_back(sat);
        exp_last.push_back(k == m_grp - 1);
        m_vxsat = m_vxsat | sat;
      end
      if (pend_en) mregs[pend_idx] = pend_data;
    end
  endtask

  task automatic send_inst(input vec_pkg::vec_inst_u x);
    int cycles;
    cycles = 0;
    @(negedge clk);
    inst_valid = 1'b1;
    inst       = x;
    while (inst_ready !== 1'b1) begin
      ready_low_seen = 1'b1;
      cycles++;
      if (cycles > 100) abort_run("Instruction input stayed blocked for 100 cycles");
      @(negedge clk);
    end
  endtask

  task automatic release_input();
    @(negedge clk);
    inst_valid = 1'b0;
  endtask

  task automatic issue(input vec_pkg::vec_inst_u x);
    model_inst(x);
    send_inst(x);
    release_input();
  endtask

  task automatic wait_retire(output logic [2:0] vd, output logic [`VEC_VLEN-1:0] data,
                             output logic sat, last);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (rt_valid !== 1'b1) begin
      cycles++;
      if (cycles > 100) abort_run("No retire arrived within 100 cycles");
      @(negedge clk);
    end
    vd   = rt_vd;
    data = rt_data;
    sat  = rt_vxsat;
    last = rt_last;
  endtask

  task automatic collect_retires(input int n);
    logic [2:0]           vd;
    logic [`VEC_VLEN-1:0] data;
    logic                 sat;
    logic                 last;
    for (int k = 0; k < n; k++) begin
      wait_retire(vd, data, sat, last);
      check_vd("rt_vd", exp_vd.pop_front(), vd);
      check_data("rt_data", exp_data.pop_front(), data);
      check_flag("rt_vxsat", exp_sat.pop_front(), sat);
      check_flag("rt_last", exp_last.pop_front(), last);
    end
  endtask

  // Sticky flag settles one edge after the last retire
  task automatic run_arith(input vec_pkg::vec_inst_u x);
    issue(x);
    collect_retires(exp_vd.size());
    @(negedge clk);
    check_flag("sticky vxsat", m_vxsat, vxsat);
  endtask

  task automatic read_reg(input logic [2:0] idx, output logic [`VEC_VLEN-1:0] d);
    @(negedge clk);
    dbg_idx = idx;
    #1;
    d = dbg_data;
  endtask

  task automatic check_all_regs();
    logic [`VEC_VLEN-1:0] d;
    for (int i = 0; i < `VEC_NUM_VREG; i++) begin
      read_reg(3'(i), d);
      check_data($sformatf("v%0d readback", i), mregs[i], d);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("%s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", cur_test, test_errs);
    end
  endtask

  task automatic test_splat_readback();
    begin_test("splat_readback");
    check_flag("inst_ready after reset", 1'b1, inst_ready);
    check_flag("vxsat after reset", 1'b0, vxsat);
    issue(make_cfg(1'b0, 2'd0, 1'b0));
    run_arith(make_arith(vec_pkg::op_splat, 3'd1, 3'd0, 3'd0, 16'(next_rand())));
    run_arith(make_arith(vec_pkg::op_splat, 3'd2, 3'd0, 3'd0, 16'(next_rand())));
    check_all_regs();
    end_test();
  endtask

  task automatic test_sat_add();
    logic [`VEC_VLEN-1:0] d;
    int                   cycles;
    begin_test("sat_add_8bit");
    run_arith(make_arith(vec_pkg::op_splat, 3'd1, 3'd0, 3'd0, 16'd100));
    run_arith(make_arith(vec_pkg::op_splat, 3'd2, 3'd0, 3'd0, 16'd50));
    run_arith(make_arith(vec_pkg::op_sadd, 3'd3, 3'd1, 3'd2, 16'd0));
    read_reg(3'd3, d);
    check_data("v3 lanes at 127", 64'h7f7f_7f7f_7f7f_7f7f, d);
    check_flag("sticky vxsat set", 1'b1, vxsat);
    issue(make_cfg(1'b0, 2'd0, 1'b1));
    cycles = 0;
    while (vxsat !== 1'b0) begin
      cycles++;
      if (cycles > 20) abort_run("Sticky vxsat did not clear after a clearing configuration");
      @(negedge clk);
    end
    end_test();
  endtask

  task automatic test_group_wrap();
    logic [`VEC_VLEN-1:0] d;
    begin_test("group_wrap");
    issue(make_cfg(1'b1, 2'd0, 1'b0));
    // Minus 30000 in v6, 10000 in v7
    run_arith(make_arith(vec_pkg::op_splat, 3'd6, 3'd0, 3'd0, 16'h8ad0));
    run_arith(make_arith(vec_pkg::op_splat, 3'd7, 3'd0, 3'd0, 16'h2710));
    issue(make_cfg(1'b1, 2'd1, 1'b0));
    run_arith(make_arith(vec_pkg::op_ssub, 3'd7, 3'd6, 3'd7, 16'd0));
    read_reg(3'd7, d);
    check_data("v7 clamped low", 64'h8000_8000_8000_8000, d);
    read_reg(3'd0, d);
    check_data("v0 wrapped group", 64'h2710_2710_2710_2710, d);
    end_test();
  endtask

  task automatic test_back_pressure();
    vec_pkg::vec_inst_u burst [6];
    begin_test("back_pressure");
    issue(make_cfg(1'b0, 2'd2, 1'b0));
    for (int i = 0; i < 6; i++) begin
      burst[i] = make_arith(vec_pkg::op_splat, 3'(i), 3'd0, 3'd0, 16'(next_rand()));
      model_inst(burst[i]);
    end
    ready_low_seen = 1'b0;
    fork
      begin
        for (int i = 0; i < 6; i++) send_inst(burst[i]);
        release_input();
      end
      collect_retires(24);
    join
    if (!ready_low_seen) begin
      $display("%s: inst_ready never dropped while six instructions were pending", cur_test);
      test_errs++;
    end
    check_all_regs();
    end_test();
  endtask

  task automatic test_random_mix();
    vec_pkg::vec_inst_u x;
    logic [31:0]        r;
    begin_test("random_mix");
    for (int n = 0; n < 20; n++) begin
      r = next_rand();
      case (r[1:0])
        2'd0:    x = make_arith(vec_pkg::op_sadd, r[4:2], r[7:5], r[10:8], r[26:11]);
        2'd1:    x = make_arith(vec_pkg::op_ssub, r[4:2], r[7:5], r[10:8], r[26:11]);
        2'd2:    x = make_arith(vec_pkg::op_splat, r[4:2], r[7:5], r[10:8], r[26:11]);
        default: x = make_cfg(r[2], r[4:3], r[5]);
      endcase
      if (x.cfg.kind) issue(x);
      else run_arith(x);
    end
    check_all_regs();
    end_test();
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    dbg_idx    = '0;
    rng_state  = 32'd21;
    m_sew16    = 1'b0;
    m_grp      = 1;
    m_vxsat    = 1'b0;
    for (int i = 0; i < `VEC_NUM_VREG; i++) mregs[i] = '0;
    ready_low_seen = 1'b0;
    total_errs     = 0;
    tests_run      = 0;
    tests_failed   = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_splat_readback();
    test_sat_add();
    test_group_wrap();
    test_back_pressure();
    test_random_mix();
    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
             total_errs);
    if (total_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== logic/vec_backend.sv ====
`timescale 1ns/100ps
`include "vec_settings.svh"

module vec_backend (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 inst_valid,
  input  vec_pkg::vec_inst_u   inst,
  output logic                 inst_ready,
  output logic                 rt_valid,
  output logic [2:0]           rt_vd,
  output logic [`VEC_VLEN-1:0] rt_data,
  output logic                 rt_vxsat,
  output logic                 rt_last,
  output logic                 vxsat,
  input  logic [2:0]           dbg_idx,
  output logic [`VEC_VLEN-1:0] dbg_data
);

  // Queue to sequencer
  logic               q_valid;
  vec_pkg::vec_inst_u q_inst;
  logic               q_pop;

  // Sequencer and uop counter
  logic       cnt_load;
  logic [2:0] cnt_len;
  logic       cnt_step;
  logic [1:0] uop_idx;
  logic       uop_last;

  // Issue stage
  logic [2:0]           rd_a_idx;
  logic [2:0]           rd_b_idx;
  logic [`VEC_VLEN-1:0] rd_a_data;
  logic [`VEC_VLEN-1:0] rd_b_data;
  logic                 iss_valid;
  vec_pkg::alu_op_e     iss_op;
  logic                 iss_sew16;
  logic [2:0]           iss_vd;
  logic [15:0]          iss_imm;
  logic                 iss_last;

  vec_cmd_queue u_cmd_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (inst_valid),
    .in_inst   (inst),
    .in_ready  (inst_ready),
    .out_valid (q_valid),
    .out_inst  (q_inst),
    .pop       (q_pop)
  );

  vec_uop_seq u_uop_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .q_valid   (q_valid),
    .q_inst    (q_inst),
    .q_pop     (q_pop),
    .cnt_load  (cnt_load),
    .cnt_len   (cnt_len),
    .cnt_step  (cnt_step),
    .uop_idx   (uop_idx),
    .uop_last  (uop_last),
    .rd_a_idx  (rd_a_idx),
    .rd_b_idx  (rd_b_idx),
    .iss_valid (iss_valid),
    .iss_op    (iss_op),
    .iss_sew16 (iss_sew16),
    .iss_vd    (iss_vd),
    .iss_imm   (iss_imm),
    .iss_last  (iss_last),
    .wb_vxsat  (rt_vxsat),
    .wb_valid  (rt_valid),
    .vxsat     (vxsat)
  );

  vec_uop_counter u_uop_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (cnt_load),
    .len   (cnt_len),
    .step  (cnt_step),
    .idx   (uop_idx),
    .last  (uop_last)
  );

  // Writeback doubles as the retire strobe
  vec_alu u_alu (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (iss_valid),
    .op       (iss_op),
    .sew16    (iss_sew16),
    .vd       (iss_vd),
    .imm      (iss_imm),
    .last     (iss_last),
    .src_a    (rd_a_data),
    .src_b    (rd_b_data),
    .wb_valid (rt_valid),
    .wb_vd    (rt_vd),
    .wb_data  (rt_data),
    .wb_vxsat (rt_vxsat),
    .wb_last  (rt_last)
  );

  vec_vrf u_vrf (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_a_idx  (rd_a_idx),
    .rd_b_idx  (rd_b_idx),
    .rd_a_data (rd_a_data),
    .rd_b_data (rd_b_data),
    .wr_en     (rt_valid),
    .wr_idx    (rt_vd),
    .wr_data   (rt_data),
    .dbg_idx   (dbg_idx),
    .dbg_data  (dbg_data)
  );

endmodule

// ==== logic/vec_vrf.sv ====
`timescale 1ns/100ps
`include "vec_settings.svh"

module vec_vrf (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [$clog2(`VEC_NUM_VREG)-1:0] rd_a_idx,
  input  logic [$clog2(`VEC_NUM_VREG)-1:0] rd_b_idx,
  output logic [`VEC_VLEN-1:0]             rd_a_data,
  output logic [`VEC_VLEN-1:0]             rd_b_data,
  input  logic                             wr_en,
  input  logic [$clog2(`VEC_NUM_VREG)-1:0] wr_idx,
  input  logic [`VEC_VLEN-1:0]             wr_data,
  input  logic [$clog2(`VEC_NUM_VREG)-1:0] dbg_idx,
  output logic [`VEC_VLEN-1:0]             dbg_data
);

  logic [`VEC_VLEN-1:0] regs [`VEC_NUM_VREG];

  // Architectural state starts at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `VEC_NUM_VREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Uop operands
  assign rd_a_data = regs[rd_a_idx];
  assign rd_b_data = regs[rd_b_idx];

  // Software view of the registers
  assign dbg_data = regs[dbg_idx];

endmodule

// ==== logic/vec_alu.sv ====
`timescale 1ns/100ps
`include "vec_settings.svh"

module vec_alu (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  vec_pkg::alu_op_e     op,
  input  logic                 sew16,
  input  logic [2:0]           vd,
  input  logic [15:0]          imm,
  input  logic                 last,
  input  logic [`VEC_VLEN-1:0] src_a,
  input  logic [`VEC_VLEN-1:0] src_b,
  output logic                 wb_valid,
  output logic [2:0]           wb_vd,
  output logic [`VEC_VLEN-1:0] wb_data,
  output logic                 wb_vxsat,
  output logic                 wb_last
);

  localparam int LANES8 = `VEC_VLEN / 8;

  logic [`VEC_VLEN-1:0] res;
  logic                 sat;

  // One loop serves both element widths, lanes are placed by shift and mask
  always_comb begin : lane_calc
    int                   w;
    int                   lanes;
    logic [`VEC_VLEN-1:0] a_sh;
    logic [`VEC_VLEN-1:0] b_sh;
    logic [`VEC_VLEN-1:0] mask;
    logic signed [16:0]   a_e;
    logic signed [16:0]   b_e;
    logic signed [16:0]   s_e;
    logic signed [16:0]   r_e;
    logic signed [16:0]   hi;
    logic signed [16:0]   lo;
    w     = sew16 ? 16 : 8;
    lanes = sew16 ? LANES8 / 2 : LANES8;
    hi    = sew16 ? 17'sd32767 : 17'sd127;
    lo    = sew16 ? -17'sd32768 : -17'sd128;
    mask  = sew16 ? {{(`VEC_VLEN - 16){1'b0}}, 16'hffff} : {{(`VEC_VLEN - 8){1'b0}}, 8'hff};
    res   = '0;
    sat   = 1'b0;
    for (int i = 0; i < LANES8; i++) begin
      if (i < lanes) begin
        a_sh = src_a >> (i * w);
        b_sh = src_b >> (i * w);
        a_e  = sew16 ? 17'(signed'(a_sh[15:0])) : 17'(signed'(a_sh[7:0]));
        b_e  = sew16 ? 17'(signed'(b_sh[15:0])) : 17'(signed'(b_sh[7:0]));
        case (op)
          vec_pkg::op_sadd:  s_e = a_e + b_e;
          vec_pkg::op_ssub:  s_e = a_e - b_e;
          vec_pkg::op_splat: s_e = sew16 ? 17'(signed'(imm)) : 17'(signed'(imm[7:0]));
          default:           s_e = '0;
        endcase
        // Clamp to the signed range of the element
        if (s_e > hi) begin
          r_e = hi;
          sat = 1'b1;
        end else if (s_e < lo) begin
          r_e = lo;
          sat = 1'b1;
        end else begin
          r_e = s_e;
        end
        res = res | (({{(`VEC_VLEN - 17){1'b0}}, r_e} & mask) << (i * w));
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      wb_vxsat <= 1'b0;
      wb_last  <= 1'b0;
    end else begin
      wb_valid <= in_valid;
      wb_vxsat <= in_valid && sat;
      wb_last  <= in_valid && last;
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (in_valid) begin
      wb_vd   <= vd;
      wb_data <= res;
    end
  end

endmodule

// ==== logic/vec_uop_seq.sv ====
`timescale 1ns/100ps
`include "vec_settings.svh"

module vec_uop_seq (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               q_valid,
  input  vec_pkg::vec_inst_u q_inst,
  output logic               q_pop,
  output logic               cnt_load,
  output logic [2:0]         cnt_len,
  output logic               cnt_step,
  input  logic [1:0]         uop_idx,
  input  logic               uop_last,
  output logic [2:0]         rd_a_idx,
  output logic [2:0]         rd_b_idx,
  output logic               iss_valid,
  output vec_pkg::alu_op_e   iss_op,
  output logic               iss_sew16,
  output logic [2:0]         iss_vd,
  output logic [15:0]        iss_imm,
  output logic               iss_last,
  input  logic               wb_vxsat,
  input  logic               wb_valid,
  output logic               vxsat
);

  typedef enum logic {
    IDLE,
    ISSUE
  } state_e;

  state_e             state;
  vec_pkg::vec_inst_u inst_q;
  logic               sew16_q;
  logic [2:0]         grp_q;
  logic [2:0]         grp_new;
  logic               is_cfg;

  assign is_cfg = q_inst.cfg.kind;

  // Pop only while idle, one instruction per visit
  assign q_pop    = (state == IDLE) && q_valid;
  assign cnt_load = q_pop && !is_cfg;
  assign cnt_len  = grp_q;
  assign cnt_step = (state == ISSUE);

  // Encoded LMUL to group size, 3 saturates at the largest group
  always_comb begin
    case (q_inst.cfg.lmul_log)
      2'd0:    grp_new = 3'd1;
      2'd1:    grp_new = 3'd2;
      default: grp_new = 3'(`VEC_MAX_LMUL);
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      sew16_q <= 1'b0;
      grp_q   <= 3'd1;
    end else begin
      case (state)
        IDLE: begin
          if (q_pop && is_cfg) begin
            sew16_q <= q_inst.cfg.sew16;
            grp_q   <= grp_new;
          end else if (q_pop) begin
            state <= ISSUE;
          end
        end
        ISSUE: begin
          if (uop_last) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Held for the issue cycles of this instruction
  always_ff @(posedge clk) begin
    if (cnt_load) begin
      inst_q <= q_inst;
    end
  end

  // A clear from a newer config wins over a retire of an older instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vxsat <= 1'b0;
    end else if (q_pop && is_cfg && q_inst.cfg.clr_vxsat) begin
      vxsat <= 1'b0;
    end else if (wb_valid && wb_vxsat) begin
      vxsat <= 1'b1;
    end
  end

  // Register indices advance with the uop and wrap modulo 8
  assign rd_a_idx  = inst_q.arith.vs1 + {1'b0, uop_idx};
  assign rd_b_idx  = inst_q.arith.vs2 + {1'b0, uop_idx};
  assign iss_vd    = inst_q.arith.vd + {1'b0, uop_idx};
  assign iss_valid = (state == ISSUE);
  assign iss_op    = inst_q.arith.op;
  assign iss_imm   = inst_q.arith.imm;
  assign iss_sew16 = sew16_q;
  assign iss_last  = uop_last;

endmodule

// ==== logic/vec_uop_counter.sv ====
`timescale 1ns/100ps

module vec_uop_counter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load,
  input  logic [2:0] len,
  input  logic       step,
  output logic [1:0] idx,
  output logic       last
);

  logic [2:0] len_q;

  // Group size of 1 after reset, so a lone uop is also the last one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx   <= '0;
      len_q <= 3'd1;
    end else if (load) begin
      idx   <= '0;
      len_q <= len;
    end else if (step) begin
      idx <= idx + 1'b1;
    end
  end

  assign last = ({1'b0, idx} == (len_q - 3'd1));

endmodule

// ==== logic/vec_cmd_queue.sv ====
`timescale 1ns/100ps
`include "vec_settings.svh"

module vec_cmd_queue (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  vec_pkg::vec_inst_u in_inst,
  output logic               in_ready,
  output logic               out_valid,
  output vec_pkg::vec_inst_u out_inst,
  input  logic               pop
);

  localparam int PTR_W = $clog2(`VEC_CMDQ_DEPTH);

  vec_pkg::vec_inst_u mem [`VEC_CMDQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             take;

  assign in_ready  = (count != (PTR_W + 1)'(`VEC_CMDQ_DEPTH));
  assign out_valid = (count != '0);
  assign out_inst  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign take = pop && out_valid;

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_inst;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`VEC_CMDQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (take) begin
        rd_ptr <= (rd_ptr == PTR_W'(`VEC_CMDQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the occupancy unchanged
      case ({push, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== logic/vec_pkg.sv ====
package vec_pkg;

  // ALU operations carried in the arithmetic view
  typedef enum logic [2:0] {
    op_sadd  = 3'd0,
    op_ssub  = 3'd1,
    op_splat = 3'd2
  } alu_op_e;

  // Arithmetic instruction, kind is 0
  typedef struct packed {
    logic        kind;
    alu_op_e     op;
    logic [2:0]  vd;
    logic [2:0]  vs1;
    logic [2:0]  vs2;
    logic [15:0] imm;
    logic [2:0]  reserved;
  } arith_view_t;

  // Configuration instruction, kind is 1
  typedef struct packed {
    logic        kind;
    logic        sew16;
    logic [1:0]  lmul_log;
    logic        clr_vxsat;
    logic [26:0] reserved;
  } config_view_t;

  // Both views keep kind in bit 31, so either one can be used to tell them apart
  typedef union packed {
    arith_view_t  arith;
    config_view_t cfg;
  } vec_inst_u;

endpackage

// ==== logic/vec_settings.svh ====
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

// Architectural register count, indices wrap modulo this value
`define VEC_NUM_VREG 8

// Width of one vector register in bits
`define VEC_VLEN 64

// Entries in the instruction FIFO
`define VEC_CMDQ_DEPTH 4

// Largest register group one instruction can span
`define VEC_MAX_LMUL 4

`endif
